// ==== logic/riscv_isa_pkg.sv ====
// ----------------------------------------------------------
// RV32I base ISA encodings shared by the decode stage.
// Major opcodes, funct3 codes and field bit positions of a
// 32-bit instruction word.
// ----------------------------------------------------------
`default_nettype none

package riscv_isa_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;

    // Field positions within the instruction word
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    // ----------------------------------------------------------
    // funct3 codes
    // ----------------------------------------------------------
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_B    = 3'b000; // Load and store sizes
    localparam logic [2:0] F3_H    = 3'b001;
    localparam logic [2:0] F3_W    = 3'b010;
    localparam logic [2:0] F3_BU   = 3'b100;
    localparam logic [2:0] F3_HU   = 3'b101;

    localparam logic [2:0] F3_ADD  = 3'b000; // ADD or SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

`default_nettype wire

// ==== logic/uop_pkg.sv ====
// ----------------------------------------------------------
// Micro-op and operand select encodings passed from the
// instruction decoder to operand gather and execute.
// All zero encodings mean "no operation".
// ----------------------------------------------------------
`default_nettype none

package uop_pkg;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic [3:0] {
        LSU_NONE,
        LSU_LB,
        LSU_LBU,
        LSU_LH,
        LSU_LHU,
        LSU_LW,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_op_t;

    typedef enum logic [2:0] {
        CFU_NOP,
        CFU_BEQ,
        CFU_BNE,
        CFU_BLT,
        CFU_BGE,
        CFU_BLTU,
        CFU_BGEU,
        CFU_JAL  // Also used for jalr
    } cfu_op_t;

    // ----------------------------------------------------------
    // Operand sources
    // ----------------------------------------------------------
    typedef enum logic [1:0] {A_ZERO, A_RS1, A_PC} opr_a_sel_t;
    typedef enum logic [1:0] {B_ZERO, B_RS2, B_IMM} opr_b_sel_t;
    typedef enum logic [1:0] {C_ZERO, C_RS2, C_IMM, C_NPC} opr_c_sel_t;

    // Immediate format feeding operand B or C
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_t;

endpackage

`default_nettype wire

// ==== logic/instr_decoder.sv ====
// ----------------------------------------------------------
// RV32I instruction decoder. Purely combinational, turns one
// instruction into register addresses, micro-ops and the
// operand selects used by operand gather.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
    import riscv_isa_pkg::*;
    import uop_pkg::*;
(
    input  logic [INSTR_W-1:0]    instr,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [REG_ADDR_W-1:0] rd,
    output alu_op_t               alu_op,
    output lsu_op_t               lsu_op,
    output cfu_op_t               cfu_op,
    output opr_a_sel_t            a_sel,
    output opr_b_sel_t            b_sel,
    output opr_c_sel_t            c_sel,
    output imm_sel_t              imm_sel,
    output logic                  is_jal
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t    alu_f3;     // ALU op for OP / OP-IMM

    assign opcode   = opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);
    assign funct3   = instr[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7   = instr[FUNCT7_MSB:FUNCT7_LSB];
    assign rs1_addr = instr[RS1_MSB:RS1_LSB];
    assign rs2_addr = instr[RS2_MSB:RS2_LSB];
    assign rd       = instr[RD_MSB:RD_LSB];

    // Bit 30 selects SUB only for register ops, for OP-IMM it is immediate data
    always_comb begin
        case (funct3)
            F3_ADD:  alu_f3 = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_f3 = ALU_SLL;
            F3_SLT:  alu_f3 = ALU_SLT;
            F3_SLTU: alu_f3 = ALU_SLTU;
            F3_XOR:  alu_f3 = ALU_XOR;
            F3_SR:   alu_f3 = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    // ----------------------------------------------------------
    // Micro-op and operand select decode
    // ----------------------------------------------------------
    always_comb begin
        alu_op  = ALU_NOP;
        lsu_op  = LSU_NONE;
        cfu_op  = CFU_NOP;
        a_sel   = A_ZERO;
        b_sel   = B_ZERO;
        c_sel   = C_ZERO;
        imm_sel = IMM_I;
        is_jal  = 1'b0;
        case (opcode)
            OPC_BRANCH: begin
                alu_op  = ALU_SUB;  // Compare via subtract
                a_sel   = A_RS1;
                b_sel   = B_RS2;
                c_sel   = C_IMM;    // Branch offset
                imm_sel = IMM_B;
                case (funct3)
                    F3_BEQ:  cfu_op = CFU_BEQ;
                    F3_BNE:  cfu_op = CFU_BNE;
                    F3_BLT:  cfu_op = CFU_BLT;
                    F3_BGE:  cfu_op = CFU_BGE;
                    F3_BLTU: cfu_op = CFU_BLTU;
                    F3_BGEU: cfu_op = CFU_BGEU;
                    default: cfu_op = CFU_NOP;
                endcase
            end
            OPC_JAL: begin
                cfu_op  = CFU_JAL;
                a_sel   = A_PC;
                b_sel   = B_IMM;
                c_sel   = C_NPC;    // Link address
                imm_sel = IMM_J;
                is_jal  = 1'b1;
            end
            OPC_JALR: begin
                cfu_op  = CFU_JAL;
                a_sel   = A_RS1;
                b_sel   = B_IMM;
                c_sel   = C_NPC;
            end
            OPC_LUI: begin
                alu_op  = ALU_OR;   // 0 | imm
                b_sel   = B_IMM;
                imm_sel = IMM_U;
            end
            OPC_AUIPC: begin
                alu_op  = ALU_ADD;
                a_sel   = A_PC;
                b_sel   = B_IMM;
                imm_sel = IMM_U;
            end
            OPC_LOAD: begin
                alu_op  = ALU_ADD;  // Address generation
                a_sel   = A_RS1;
                b_sel   = B_IMM;
                case (funct3)
                    F3_B:    lsu_op = LSU_LB;
                    F3_H:    lsu_op = LSU_LH;
                    F3_W:    lsu_op = LSU_LW;
                    F3_BU:   lsu_op = LSU_LBU;
                    F3_HU:   lsu_op = LSU_LHU;
                    default: lsu_op = LSU_NONE;
                endcase
            end
            OPC_STORE: begin
                alu_op  = ALU_ADD;
                a_sel   = A_RS1;
                b_sel   = B_IMM;
                c_sel   = C_RS2;    // Store data
                imm_sel = IMM_S;
                case (funct3)
                    F3_B:    lsu_op = LSU_SB;
                    F3_H:    lsu_op = LSU_SH;
                    F3_W:    lsu_op = LSU_SW;
                    default: lsu_op = LSU_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                alu_op  = alu_f3;
                a_sel   = A_RS1;
                b_sel   = B_IMM;
            end
            OPC_OP: begin
                alu_op  = alu_f3;
                a_sel   = A_RS1;
                b_sel   = B_RS2;
            end
            default: begin
                // Unsupported opcode leaves everything as NOP
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/imm_extract.sv ====
// ----------------------------------------------------------
// Immediate extraction. Builds the I, S, B, U and J formats
// sign-extended to XLEN and returns the one chosen by the
// decoder's immediate select.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module imm_extract
    import riscv_isa_pkg::*;
    import uop_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic [INSTR_W-1:0] instr,
    input  imm_sel_t           imm_sel,
    output logic [XLEN-1:0]    imm
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Sign bit is always instr[31]
    assign imm_i = {{(XLEN-11){instr[31]}}, instr[30:20]};
    assign imm_s = {{(XLEN-11){instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{(XLEN-31){instr[31]}}, instr[30:12], 12'b0};
    assign imm_j = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = imm_i;
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/operand_gather.sv ====
// ----------------------------------------------------------
// Operand gather. Drives execute operands A, B and C from the
// forwarded register data, the PC, the next PC and the
// extracted immediate, according to the decoded selects.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module operand_gather
    import uop_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  opr_a_sel_t      a_sel,
    input  opr_b_sel_t      b_sel,
    input  opr_c_sel_t      c_sel,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] opr_a,
    output logic [XLEN-1:0] opr_b,
    output logic [XLEN-1:0] opr_c
);

    logic [XLEN-1:0] npc;

    assign npc = pc + XLEN'(4);   // No compressed instructions

    always_comb begin
        case (a_sel)
            A_RS1:   opr_a = rs1_data;
            A_PC:    opr_a = pc;
            default: opr_a = '0;
        endcase

        case (b_sel)
            B_RS2:   opr_b = rs2_data;
            B_IMM:   opr_b = imm;
            default: opr_b = '0;
        endcase

        case (c_sel)
            C_RS2:   opr_c = rs2_data;
            C_IMM:   opr_c = imm;
            C_NPC:   opr_c = npc;
            default: opr_c = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/decode_flow_ctrl.sv ====
// ----------------------------------------------------------
// Decode stage flow control. Raises the jal control flow
// change toward fetch and derives s2_valid and the fetch
// consume level, holding both off until fetch acknowledges.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module decode_flow_ctrl
    import riscv_isa_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic               s1_valid,
    input  logic               is_jal,
    input  logic               s2_ready,
    input  logic               cf_ack,
    input  logic [XLEN-1:0]    pc,
    input  logic [INSTR_W-1:0] instr,
    output logic               cf_valid,
    output logic [XLEN-1:0]    cf_target,
    output logic               s2_valid,
    output logic               eat
);

    logic [XLEN-1:0] j_offset;
    logic            cf_wait;

    // J-type offset straight from the instruction bits
    assign j_offset  = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20],
                        instr[30:21], 1'b0};
    assign cf_target = pc + j_offset;

    // Only raise the jump once execute can take the instruction, otherwise
    // fetch would flush its buffer before decode has handed it on
    assign cf_valid = s1_valid && is_jal && s2_ready;
    assign cf_wait  = cf_valid && !cf_ack;

    assign s2_valid = s1_valid && (!cf_valid || cf_ack);
    assign eat      = s1_valid && s2_ready && !cf_wait;

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
// ----------------------------------------------------------
// Decode and operand gather stage, RV32I. Decodes the fetched
// instruction, reads operands through the register file port
// and registers the micro-op bundle toward execute.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import riscv_isa_pkg::*;
    import uop_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  g_clk,
    input  logic                  reset,

    input  logic                  s1_valid,
    input  logic [INSTR_W-1:0]    s1_instr,
    input  logic [XLEN-1:0]       s1_pc,
    output logic                  s1_eat,       // Fetch instr consumed at next edge

    output logic                  s1_cf_valid,
    output logic [XLEN-1:0]       s1_cf_target,
    input  logic                  s1_cf_ack,

    output logic [REG_ADDR_W-1:0] s1_rs1_addr,
    output logic [REG_ADDR_W-1:0] s1_rs2_addr,
    input  logic [XLEN-1:0]       s1_rs1_data,  // Forwarded
    input  logic [XLEN-1:0]       s1_rs2_data,

    output logic                  s2_valid,
    input  logic                  s2_ready,
    output logic [XLEN-1:0]       s2_pc,
    output logic [XLEN-1:0]       s2_opr_a,
    output logic [XLEN-1:0]       s2_opr_b,
    output logic [XLEN-1:0]       s2_opr_c,
    output logic [REG_ADDR_W-1:0] s2_rd,
    output alu_op_t               s2_alu_op,
    output lsu_op_t               s2_lsu_op,
    output cfu_op_t               s2_cfu_op
);

    logic [REG_ADDR_W-1:0] dec_rd;
    alu_op_t               dec_alu_op;
    lsu_op_t               dec_lsu_op;
    cfu_op_t               dec_cfu_op;
    opr_a_sel_t            dec_a_sel;
    opr_b_sel_t            dec_b_sel;
    opr_c_sel_t            dec_c_sel;
    imm_sel_t              dec_imm_sel;
    logic                  dec_is_jal;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       n_opr_a;
    logic [XLEN-1:0]       n_opr_b;
    logic [XLEN-1:0]       n_opr_c;

    // ----------------------------------------------------------
    // Decode and operand selection
    // ----------------------------------------------------------
    instr_decoder u_decoder (
        .instr    (s1_instr),
        .rs1_addr (s1_rs1_addr),
        .rs2_addr (s1_rs2_addr),
        .rd       (dec_rd),
        .alu_op   (dec_alu_op),
        .lsu_op   (dec_lsu_op),
        .cfu_op   (dec_cfu_op),
        .a_sel    (dec_a_sel),
        .b_sel    (dec_b_sel),
        .c_sel    (dec_c_sel),
        .imm_sel  (dec_imm_sel),
        .is_jal   (dec_is_jal)
    );

    imm_extract #(.XLEN(XLEN)) u_imm (
        .instr   (s1_instr),
        .imm_sel (dec_imm_sel),
        .imm     (imm)
    );

    operand_gather #(.XLEN(XLEN)) u_gather (
        .a_sel    (dec_a_sel),
        .b_sel    (dec_b_sel),
        .c_sel    (dec_c_sel),
        .rs1_data (s1_rs1_data),
        .rs2_data (s1_rs2_data),
        .pc       (s1_pc),
        .imm      (imm),
        .opr_a    (n_opr_a),
        .opr_b    (n_opr_b),
        .opr_c    (n_opr_c)
    );

    decode_flow_ctrl #(.XLEN(XLEN)) u_flow (
        .s1_valid  (s1_valid),
        .is_jal    (dec_is_jal),
        .s2_ready  (s2_ready),
        .cf_ack    (s1_cf_ack),
        .pc        (s1_pc),
        .instr     (s1_instr),
        .cf_valid  (s1_cf_valid),
        .cf_target (s1_cf_target),
        .s2_valid  (s2_valid),
        .eat       (s1_eat)
    );

    // ----------------------------------------------------------
    // Decode to execute register
    // ----------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (reset) begin
            s2_pc     <= '0;
            s2_opr_a  <= '0;
            s2_opr_b  <= '0;
            s2_opr_c  <= '0;
            s2_rd     <= '0;
            s2_alu_op <= ALU_NOP;
            s2_lsu_op <= LSU_NONE;
            s2_cfu_op <= CFU_NOP;
        end else if (s2_valid && s2_ready) begin
            s2_pc     <= s1_pc;
            s2_opr_a  <= n_opr_a;
            s2_opr_b  <= n_opr_b;
            s2_opr_c  <= n_opr_c;
            s2_rd     <= dec_rd;
            s2_alu_op <= dec_alu_op;
            s2_lsu_op <= dec_lsu_op;
            s2_cfu_op <= dec_cfu_op;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/decode_ref.svh ====
// ----------------------------------------------------------
// Expected execute bundle for one RV32I instruction, built
// straight from the ISA encodings. Included inside the
// testbench module, which imports uop_pkg for the op codes.
// ----------------------------------------------------------
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Bundle layout {pc, opr_a, opr_b, opr_c, rd, alu_op, lsu_op, cfu_op}
localparam int REF_W     = 4 * 32 + 5 + 4 + 4 + 3;
localparam int OPR_B_LSB = 32 + 5 + 4 + 4 + 3;

function automatic logic [REF_W-1:0] decode_ref(
    input logic [31:0] ins,
    input logic [31:0] pc,
    input logic [31:0] rs1v,
    input logic [31:0] rs2v
);
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    alu_op_t     alu;
    lsu_op_t     lsu;
    cfu_op_t     cfu;
    alu_op_t     arith;  // Register and immediate ALU ops

    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    case (ins[14:12])
        3'b000:  arith = (ins[6:0] == 7'b0110011 && ins[30]) ? ALU_SUB : ALU_ADD;
        3'b001:  arith = ALU_SLL;
        3'b010:  arith = ALU_SLT;
        3'b011:  arith = ALU_SLTU;
        3'b100:  arith = ALU_XOR;
        3'b101:  arith = ins[30] ? ALU_SRA : ALU_SRL;
        3'b110:  arith = ALU_OR;
        default: arith = ALU_AND;
    endcase

    a   = '0;
    b   = '0;
    c   = '0;
    alu = ALU_NOP;
    lsu = LSU_NONE;
    cfu = CFU_NOP;
    case (ins[6:0])
        7'b1100011: begin  // Branch
            alu = ALU_SUB;
            a   = rs1v;
            b   = rs2v;
            c   = imm_b;
            case (ins[14:12])
                3'b000:  cfu = CFU_BEQ;
                3'b001:  cfu = CFU_BNE;
                3'b100:  cfu = CFU_BLT;
                3'b101:  cfu = CFU_BGE;
                3'b110:  cfu = CFU_BLTU;
                3'b111:  cfu = CFU_BGEU;
                default: cfu = CFU_NOP;
            endcase
        end
        7'b1101111: begin  // jal
            cfu = CFU_JAL;
            a   = pc;
            b   = imm_j;
            c   = pc + 32'd4;
        end
        7'b1100111: begin  // jalr
            cfu = CFU_JAL;
            a   = rs1v;
            b   = imm_i;
            c   = pc + 32'd4;
        end
        7'b0110111: begin  // lui
            alu = ALU_OR;
            b   = imm_u;
        end
        7'b0010111: begin  // auipc
            alu = ALU_ADD;
            a   = pc;
            b   = imm_u;
        end
        7'b0000011: begin  // Load
            alu = ALU_ADD;
            a   = rs1v;
            b   = imm_i;
            case (ins[14:12])
                3'b000:  lsu = LSU_LB;
                3'b001:  lsu = LSU_LH;
                3'b010:  lsu = LSU_LW;
                3'b100:  lsu = LSU_LBU;
                3'b101:  lsu = LSU_LHU;
                default: lsu = LSU_NONE;
            endcase
        end
        7'b0100011: begin  // Store
            alu = ALU_ADD;
            a   = rs1v;
            b   = imm_s;
            c   = rs2v;
            case (ins[14:12])
                3'b000:  lsu = LSU_SB;
                3'b001:  lsu = LSU_SH;
                3'b010:  lsu = LSU_SW;
                default: lsu = LSU_NONE;
            endcase
        end
        7'b0010011: begin  // OP-IMM
            alu = arith;
            a   = rs1v;
            b   = imm_i;
        end
        7'b0110011: begin  // OP
            alu = arith;
            a   = rs1v;
            b   = rs2v;
        end
        default: begin
            // Anything else stays a bubble
        end
    endcase
    return {pc, a, b, c, ins[11:7], alu, lsu, cfu};
endfunction

`endif

// ==== testbench/decode_stage_tb.sv ====
// ----------------------------------------------------------
// Testbench for the decode stage. Presents RV32I instructions
// from fetch, models the register file and compares the
// execute bundle and handshakes with decode_ref.
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb
    import uop_pkg::*;
();

    localparam int XLEN        = 32;
    localparam int N_OPS       = 40;  // Random OP and OP-IMM
    localparam int N_MIXED     = 40;
    localparam int N_JAL       = 4;
    localparam int N_STALL     = 4;
    localparam int STIM_CYCLES = 10 + N_OPS + N_MIXED + N_JAL * (N_JAL + 2)
                                 + 3 * (N_STALL + 1);
    localparam int MAX_CYCLES  = 2 * STIM_CYCLES;
    localparam logic [XLEN-1:0] RF_SCALE = 32'h0131_5ac7;

    logic            g_clk;
    logic            reset;
    logic            s1_valid;
    logic [31:0]     s1_instr;
    logic [XLEN-1:0] s1_pc;
    logic            s1_eat;
    logic            s1_cf_valid;
    logic [XLEN-1:0] s1_cf_target;
    logic            s1_cf_ack;
    logic [4:0]      s1_rs1_addr;
    logic [4:0]      s1_rs2_addr;
    logic [XLEN-1:0] s1_rs1_data;
    logic [XLEN-1:0] s1_rs2_data;
    logic            s2_valid;
    logic            s2_ready;
    logic [XLEN-1:0] s2_pc;
    logic [XLEN-1:0] s2_opr_a;
    logic [XLEN-1:0] s2_opr_b;
    logic [XLEN-1:0] s2_opr_c;
    logic [4:0]      s2_rd;
    alu_op_t         s2_alu_op;
    lsu_op_t         s2_lsu_op;
    cfu_op_t         s2_cfu_op;

    `include "decode_ref.svh"

    logic [REF_W-1:0] dut_bundle;
    logic [REF_W-1:0] exp_bundle;
    logic [REF_W-1:0] cur_ref;
    logic [31:0]      exp_instr;
    logic             exp_cf;
    logic             exp_wait;
    logic             exp_s2v;
    logic             exp_eat;
    logic             armed;
    integer           seed;
    int               cycles = 0;
    int               n_issued = 0;
    int               n_accepted = 0;
    int               bundle_errors = 0;
    int               flow_errors = 0;
    int               other_errors = 0;

    decode_stage #(.XLEN(XLEN)) UUT (
        .g_clk        (g_clk),
        .reset        (reset),
        .s1_valid     (s1_valid),
        .s1_instr     (s1_instr),
        .s1_pc        (s1_pc),
        .s1_eat       (s1_eat),
        .s1_cf_valid  (s1_cf_valid),
        .s1_cf_target (s1_cf_target),
        .s1_cf_ack    (s1_cf_ack),
        .s1_rs1_addr  (s1_rs1_addr),
        .s1_rs2_addr  (s1_rs2_addr),
        .s1_rs1_data  (s1_rs1_data),
        .s1_rs2_data  (s1_rs2_data),
        .s2_valid     (s2_valid),
        .s2_ready     (s2_ready),
        .s2_pc        (s2_pc),
        .s2_opr_a     (s2_opr_a),
        .s2_opr_b     (s2_opr_b),
        .s2_opr_c     (s2_opr_c),
        .s2_rd        (s2_rd),
        .s2_alu_op    (s2_alu_op),
        .s2_lsu_op    (s2_lsu_op),
        .s2_cfu_op    (s2_cfu_op)
    );

    // Register file content is a fixed function of the address
    function automatic logic [XLEN-1:0] rf_value(input logic [4:0] addr);
        return XLEN'(addr) * RF_SCALE;
    endfunction

    function automatic logic [6:0] mixed_opcode(input int k);
        case (k)
            0:       return 7'b0000011;  // Load
            1:       return 7'b0100011;  // Store
            2:       return 7'b1100011;  // Branch
            3:       return 7'b0110111;  // lui
            4:       return 7'b0010111;  // auipc
            default: return 7'b1100111;  // jalr
        endcase
    endfunction

    assign s1_rs1_data = rf_value(s1_rs1_addr);
    assign s1_rs2_data = rf_value(s1_rs2_addr);
    assign dut_bundle  = {s2_pc, s2_opr_a, s2_opr_b, s2_opr_c, s2_rd,
                          s2_alu_op, s2_lsu_op, s2_cfu_op};

    always #2 g_clk = ~g_clk;

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Flow checks and expected bundle at the rising edge
    // ----------------------------------------------------------
    always @(posedge g_clk) begin
        if (reset) begin
            exp_bundle <= '0;
            exp_instr  <= '0;
        end else if (armed) begin
            cur_ref  = decode_ref(s1_instr, s1_pc, rf_value(s1_instr[19:15]),
                                  rf_value(s1_instr[24:20]));
            exp_cf   = s1_valid && s2_ready && (s1_instr[6:0] == 7'b1101111);
            exp_wait = exp_cf && !s1_cf_ack;  // Jump raised, fetch not answered yet
            exp_s2v  = s1_valid && !exp_wait;
            exp_eat  = s1_valid && s2_ready && !exp_wait;
            if ({s1_cf_valid, s2_valid, s1_eat} !== {exp_cf, exp_s2v, exp_eat}) begin
                flow_errors = flow_errors + 1;
                $display("MISMATCH at %0t: cf_valid, s2_valid, eat = %b, expected %b",
                         $time, {s1_cf_valid, s2_valid, s1_eat},
                         {exp_cf, exp_s2v, exp_eat});
            end
            if ({s1_rs1_addr, s1_rs2_addr} !== {s1_instr[19:15], s1_instr[24:20]}) begin
                flow_errors = flow_errors + 1;
                $display("MISMATCH at %0t: rs1/rs2 address %h/%h, expected %h/%h",
                         $time, s1_rs1_addr, s1_rs2_addr,
                         s1_instr[19:15], s1_instr[24:20]);
            end
            if (exp_cf && s1_cf_target !== s1_pc + cur_ref[OPR_B_LSB +: 32]) begin
                flow_errors = flow_errors + 1;
                $display("MISMATCH at %0t: jal target %h, expected %h", $time,
                         s1_cf_target, s1_pc + cur_ref[OPR_B_LSB +: 32]);
            end
            if (exp_s2v && s2_ready) begin
                exp_bundle <= cur_ref;
                exp_instr  <= s1_instr;
                n_accepted = n_accepted + 1;
            end
        end
    end

    // Registered outputs are stable at the falling edge
    always @(negedge g_clk) begin
        if (armed && !reset && dut_bundle !== exp_bundle) begin
            bundle_errors = bundle_errors + 1;
            $display("MISMATCH at %0t: instr %h gave s2 bundle %h, expected %h",
                     $time, exp_instr, dut_bundle, exp_bundle);
        end
    end

    // ----------------------------------------------------------
    // Stimulus tasks enter and leave at a falling edge
    // ----------------------------------------------------------
    task automatic present(input logic [31:0] instr);
        logic [31:0] r;
        r         = $random(seed);
        s1_valid  = 1'b1;
        s1_instr  = instr;
        s1_pc     = {r[31:2], 2'b00};
        s1_cf_ack = r[1];  // Ignored unless jal
        n_issued  = n_issued + 1;
    endtask

    task automatic wait_eat();
        @(posedge g_clk);
        while (!s1_eat) begin
            @(posedge g_clk);
        end
        @(negedge g_clk);
    endtask

    task automatic issue(input logic [31:0] instr);
        present(instr);
        wait_eat();
    endtask

    task automatic issue_jal(input logic [31:0] instr, input int hold);
        present(instr);
        s1_cf_ack = 1'b0;
        repeat (hold) @(negedge g_clk);
        s1_cf_ack = 1'b1;
        wait_eat();
        s1_cf_ack = 1'b0;
    endtask

    task automatic issue_stalled(input logic [31:0] instr, input int stall);
        s2_ready = 1'b0;
        present(instr);
        s1_cf_ack = 1'b1;
        repeat (stall) @(negedge g_clk);
        s2_ready = 1'b1;
        wait_eat();
    endtask

    initial begin
        logic [31:0] r;
        int          k;
        seed      = 39;
        g_clk     = 1'b0;
        reset     = 1'b1;
        armed     = 1'b0;
        s1_valid  = 1'b0;
        s1_instr  = '0;
        s1_pc     = '0;
        s1_cf_ack = 1'b0;
        s2_ready  = 1'b1;
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        reset = 1'b0;
        armed = 1'b1;
        repeat (3) @(negedge g_clk);  // Idle after reset

        for (int i = 0; i < N_OPS; i++) begin
            r = $random(seed);
            if (r[0]) begin
                issue({r[31:7], 7'b0010011});
            end else begin
                issue({1'b0, r[30], 5'b0, r[24:7], 7'b0110011});
            end
        end

        for (int i = 0; i < N_MIXED; i++) begin
            r = $random(seed);
            k = $unsigned($random(seed)) % 6;
            issue({r[31:7], mixed_opcode(k)});
        end

        for (int i = 0; i < N_JAL; i++) begin
            r = $random(seed);
            issue_jal({r[31:7], 7'b1101111}, i + 1);
        end

        // Back-pressure from execute
        r = $random(seed);
        issue_stalled({r[31:7], 7'b0100011}, N_STALL);
        r = $random(seed);
        issue_stalled({7'b0100000, r[24:7], 7'b0110011}, N_STALL);
        r = $random(seed);
        issue_stalled({r[31:7], 7'b1101111}, N_STALL);

        s1_valid = 1'b0;
        repeat (2) @(negedge g_clk);
        if (n_accepted != n_issued) begin
            other_errors = other_errors + 1;
            $display("Accepted %0d instructions but %0d were issued", n_accepted, n_issued);
        end
        $display("Errors: bundle %0d, flow %0d, other %0d (%0d instructions accepted)",
                 bundle_errors, flow_errors, other_errors, n_accepted);
        if (bundle_errors + flow_errors + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
+incdir+testbench
logic/riscv_isa_pkg.sv
logic/uop_pkg.sv
logic/instr_decoder.sv
logic/imm_extract.sv
logic/operand_gather.sv
logic/decode_flow_ctrl.sv
logic/decode_stage.sv
testbench/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - logic/riscv_isa_pkg.sv
  - logic/uop_pkg.sv
  - logic/instr_decoder.sv
  - logic/imm_extract.sv
  - logic/operand_gather.sv
  - logic/decode_flow_ctrl.sv
  - logic/decode_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/decode_stage_tb.sv
